/* aluCluster.sv */
`timescale 1ns/1ps
`default_nettype none

module aluCluster (
    input wire clk,
    input wire rst,
    input wire allocEn,
    input wire rsTypesPkg::dataT allocOperandO,
    input wire rsTypesPkg::dataT allocOperandT,
    input wire rsTypesPkg::tagT allocTagO,
    input wire rsTypesPkg::tagT allocTagT,
    input wire rsTypesPkg::tagT allocTagW,
    input wire aluOpPkg::aluOpT allocOp,
    input wire rsTypesPkg::dataT allocImm,
    input wire rsTypesPkg::branchMaskT allocBranchMask,
    input wire lsResultValid,
    input wire rsTypesPkg::tagT lsResultTag,
    input wire rsTypesPkg::dataT lsResultData,
    input wire bFreeEn,
    input wire rsTypesPkg::branchIdT bFreeId,
    input wire misTaken,
    output logic aluResultValid,
    output rsTypesPkg::tagT aluResultTag,
    output rsTypesPkg::dataT aluResultData,
    output logic [rsTypesPkg::rsSize-1:0] freeMask
);
    dispatchIf dispatchBus ();
    issueIf issueBus ();

    assign dispatchBus.allocEn = allocEn;
    assign dispatchBus.operandO = allocOperandO;
    assign dispatchBus.operandT = allocOperandT;
    assign dispatchBus.tagO = allocTagO;
    assign dispatchBus.tagT = allocTagT;
    assign dispatchBus.tagW = allocTagW;
    assign dispatchBus.op = allocOp;
    assign dispatchBus.imm = allocImm;
    assign dispatchBus.branchMask = allocBranchMask;

    aluRs aluRs_inst (
        .clk(clk),
        .rst(rst),
        .dispatch(dispatchBus.station),
        // alu result loops back for wakeup
        .aluResultValid(aluResultValid),
        .aluResultTag(aluResultTag),
        .aluResultData(aluResultData),
        .lsResultValid(lsResultValid),
        .lsResultTag(lsResultTag),
        .lsResultData(lsResultData),
        .bFreeEn(bFreeEn),
        .bFreeId(bFreeId),
        .misTaken(misTaken),
        .issue(issueBus.station),
        .freeMask(freeMask)
    );

    aluUnit aluUnit_inst (
        .clk(clk),
        .rst(rst),
        .issue(issueBus.unit),
        .bFreeEn(bFreeEn),
        .bFreeId(bFreeId),
        .misTaken(misTaken),
        .resultValid(aluResultValid),
        .resultTag(aluResultTag),
        .resultData(aluResultData)
    );
endmodule

`default_nettype wire

/* aluClusterTb.sv */
`timescale 1ns/1ps
`default_nettype none

module aluClusterTb;
    logic clk;
    logic rst;
    logic allocEn;
    rsTypesPkg::dataT allocOperandO;
    rsTypesPkg::dataT allocOperandT;
    rsTypesPkg::tagT allocTagO;
    rsTypesPkg::tagT allocTagT;
    rsTypesPkg::tagT allocTagW;
    aluOpPkg::aluOpT allocOp;
    rsTypesPkg::dataT allocImm;
    rsTypesPkg::branchMaskT allocBranchMask;
    logic lsResultValid;
    rsTypesPkg::tagT lsResultTag;
    rsTypesPkg::dataT lsResultData;
    logic bFreeEn;
    rsTypesPkg::branchIdT bFreeId;
    logic misTaken;
    logic aluResultValid;
    rsTypesPkg::tagT aluResultTag;
    rsTypesPkg::dataT aluResultData;
    logic [rsTypesPkg::rsSize-1:0] freeMask;

    // reference model of station lines, issue register and result bus
    logic [rsTypesPkg::rsSize-1:0] lOcc;
    logic [rsTypesPkg::rsSize-1:0] lNew;
    aluOpPkg::aluOpT lOp [rsTypesPkg::rsSize];
    rsTypesPkg::tagT lTagO [rsTypesPkg::rsSize];
    rsTypesPkg::tagT lTagT [rsTypesPkg::rsSize];
    rsTypesPkg::dataT lValO [rsTypesPkg::rsSize];
    rsTypesPkg::dataT lValT [rsTypesPkg::rsSize];
    rsTypesPkg::dataT lImm [rsTypesPkg::rsSize];
    rsTypesPkg::branchMaskT lMask [rsTypesPkg::rsSize];
    logic s1Valid;
    rsTypesPkg::tagT s1Tag;
    aluOpPkg::aluOpT s1Op;
    rsTypesPkg::dataT s1O;
    rsTypesPkg::dataT s1T;
    rsTypesPkg::dataT s1Imm;
    rsTypesPkg::branchMaskT s1Mask;
    logic s2Valid;
    rsTypesPkg::tagT s2Tag;
    rsTypesPkg::dataT s2Data;
    rsTypesPkg::branchMaskT brBusy;
    logic [6:0] lsBusy;
    int allocated;
    int completed;
    int flushed;
    int cycle;
    logic drained;
    logic [15:0] lfsrState;

    aluCluster aluCluster_inst (
        .clk(clk),
        .rst(rst),
        .allocEn(allocEn),
        .allocOperandO(allocOperandO),
        .allocOperandT(allocOperandT),
        .allocTagO(allocTagO),
        .allocTagT(allocTagT),
        .allocTagW(allocTagW),
        .allocOp(allocOp),
        .allocImm(allocImm),
        .allocBranchMask(allocBranchMask),
        .lsResultValid(lsResultValid),
        .lsResultTag(lsResultTag),
        .lsResultData(lsResultData),
        .bFreeEn(bFreeEn),
        .bFreeId(bFreeId),
        .misTaken(misTaken),
        .aluResultValid(aluResultValid),
        .aluResultTag(aluResultTag),
        .aluResultData(aluResultData),
        .freeMask(freeMask)
    );

    always #50 clk = ~clk;

    function automatic logic [15:0] lfsrStep(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic rsTypesPkg::dataT expectedResult(aluOpPkg::aluOpT op,
            rsTypesPkg::dataT a, rsTypesPkg::dataT b, rsTypesPkg::dataT imm);
        case (op)
            aluOpPkg::opAdd: return a + b;
            aluOpPkg::opSub: return a - b;
            aluOpPkg::opAnd: return a & b;
            aluOpPkg::opOr: return a | b;
            aluOpPkg::opXor: return a ^ b;
            aluOpPkg::opSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluOpPkg::opAddImm: return a + imm;
            default: return rsTypesPkg::dataFree;
        endcase
    endfunction

    // which result bus carries this tag in the current cycle
    function automatic logic busHit(rsTypesPkg::tagT tag);
        return (s2Valid && tag == s2Tag) || (lsResultValid && tag == lsResultTag);
    endfunction

    function automatic rsTypesPkg::dataT busData(rsTypesPkg::tagT tag);
        return (s2Valid && tag == s2Tag) ? s2Data : lsResultData;
    endfunction

    function automatic rsTypesPkg::branchMaskT maskOf(int x);
        if (lOcc[x]) begin
            return lMask[x];
        end
        if (s1Valid && s1Tag == rsTypesPkg::aluTagBase + x) begin
            return s1Mask;
        end
        return '0;
    endfunction

    task automatic failRun(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkValid(string name, logic got, logic exp);
        if (got !== exp) begin
            failRun($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkTag(string name, rsTypesPkg::tagT got, rsTypesPkg::tagT exp);
        if (got !== exp) begin
            failRun($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkData(string name, rsTypesPkg::dataT got, rsTypesPkg::dataT exp);
        if (got !== exp) begin
            failRun($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkMask(string name, logic [rsTypesPkg::rsSize-1:0] got,
            logic [rsTypesPkg::rsSize-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // called mid-cycle when inputs and registered outputs are stable
    task automatic stepModel();
        int i;
        int pick;
        logic s1Live;
        if (aluResultValid === 1'b1) begin
            completed++;
        end
        checkValid("aluResultValid", aluResultValid, s2Valid);
        if (s2Valid) begin
            checkTag("aluResultTag", aluResultTag, s2Tag);
            checkData("aluResultData", aluResultData, s2Data);
        end
        if (allocEn) begin
            i = int'(allocTagW - rsTypesPkg::aluTagBase);
            lOcc[i] = 1'b1;
            lNew[i] = 1'b1;
            lOp[i] = allocOp;
            lTagO[i] = allocTagO;
            lTagT[i] = allocTagT;
            lValO[i] = allocOperandO;
            lValT[i] = allocOperandT;
            lImm[i] = allocImm;
            lMask[i] = allocBranchMask;
            allocated++;
        end
        for (i = 0; i < rsTypesPkg::rsSize; i++) begin
            if (busHit(lTagO[i])) begin
                lValO[i] = busData(lTagO[i]);
                lTagO[i] = rsTypesPkg::tagFree;
            end
            if (busHit(lTagT[i])) begin
                lValT[i] = busData(lTagT[i]);
                lTagT[i] = rsTypesPkg::tagFree;
            end
        end
        if (bFreeEn) begin
            for (i = 0; i < rsTypesPkg::rsSize; i++) begin
                lMask[i][bFreeId] = 1'b0;
            end
            s1Mask[bFreeId] = 1'b0;
        end
        s1Live = s1Valid;
        if (misTaken) begin
            for (i = 0; i < rsTypesPkg::rsSize; i++) begin
                if (lOcc[i] && lMask[i][bFreeId]) begin
                    lOcc[i] = 1'b0;
                    flushed++;
                end
            end
            if (s1Valid && s1Mask[bFreeId]) begin
                s1Live = 1'b0;
                flushed++;
            end
        end
        s2Valid = s1Live;
        s2Tag = s1Tag;
        s2Data = expectedResult(s1Op, s1O, s1T, s1Imm);
        // a line allocated this cycle waits one cycle before it may issue
        pick = -1;
        for (i = rsTypesPkg::rsSize - 1; i >= 0; i--) begin
            if (lOcc[i] && !lNew[i] && lTagO[i] == rsTypesPkg::tagFree
                    && lTagT[i] == rsTypesPkg::tagFree) begin
                pick = i;
            end
        end
        s1Valid = (pick >= 0);
        if (pick >= 0) begin
            s1Tag = rsTypesPkg::tagT'(rsTypesPkg::aluTagBase + pick);
            s1Op = lOp[pick];
            s1O = lValO[pick];
            s1T = lValT[pick];
            s1Imm = lImm[pick];
            s1Mask = lMask[pick];
            lOcc[pick] = 1'b0;
        end
        lNew = '0;
        checkMask("freeMask", freeMask, ~lOcc);
    endtask

    // dispatcher, branch unit and load/store unit driven at the rising edge
    task automatic driveCycle(input logic draining);
        int k;
        int v;
        int line;
        rsTypesPkg::tagT waitTag [2];
        rsTypesPkg::dataT waitVal [2];
        rsTypesPkg::branchMaskT inherit;
        logic [rsTypesPkg::rsSize-1:0] pending;
        aluOpPkg::aluOpT op;
        allocEn <= 1'b0;
        lsResultValid <= 1'b0;
        bFreeEn <= 1'b0;
        misTaken <= 1'b0;
        k = randBits(2);
        if (randBits(2) == 0) begin
            if (brBusy[k]) begin
                bFreeId <= rsTypesPkg::branchIdT'(k);
                if (randBits(1)) begin
                    bFreeEn <= 1'b1;
                end else begin
                    misTaken <= 1'b1;
                end
                brBusy[k] = 1'b0;
            end else begin
                brBusy[k] = 1'b1;
            end
        end
        for (k = 0; k < rsTypesPkg::rsSize; k++) begin
            pending[k] = lOcc[k] || (s1Valid && s1Tag == rsTypesPkg::aluTagBase + k)
                || (s2Valid && s2Tag == rsTypesPkg::aluTagBase + k);
        end
        line = randBits(2);
        if (!draining && randBits(1) && !pending[line]) begin
            v = randBits(3);
            op = aluOpPkg::aluOpT'((v == 0) ? 1 : v);
            // consumers carry their producer's branch bits
            inherit = '0;
            for (int s = 0; s < 2; s++) begin
                waitTag[s] = rsTypesPkg::tagFree;
                waitVal[s] = randBits(32);
                v = randBits(2);
                if (v == 0) begin
                    k = randBits(2);
                    if (pending[k]) begin
                        waitTag[s] = rsTypesPkg::tagT'(rsTypesPkg::aluTagBase + k);
                        inherit = inherit | maskOf(k);
                    end
                end else if (v == 1) begin
                    k = randBits(3);
                    if (k < 7) begin
                        waitTag[s] = rsTypesPkg::tagT'(rsTypesPkg::lsTagBase + k);
                        lsBusy[k] = 1'b1;
                    end
                end
            end
            if (op == aluOpPkg::opAddImm) begin
                waitTag[1] = rsTypesPkg::tagFree;
            end
            allocEn <= 1'b1;
            allocTagW <= rsTypesPkg::tagT'(rsTypesPkg::aluTagBase + line);
            allocOp <= op;
            allocTagO <= waitTag[0];
            allocTagT <= waitTag[1];
            allocOperandO <= waitVal[0];
            allocOperandT <= waitVal[1];
            allocImm <= randBits(32);
            allocBranchMask <= (rsTypesPkg::branchMaskT'(randBits(4)) & brBusy) | inherit;
        end
        v = randBits(3);
        if (draining) begin
            for (k = 6; k >= 0; k--) begin
                if (lsBusy[k]) begin
                    v = k;
                end
            end
        end
        if (v < 7 && lsBusy[v] && (draining || randBits(1) == 0)) begin
            lsResultValid <= 1'b1;
            lsResultTag <= rsTypesPkg::tagT'(rsTypesPkg::lsTagBase + v);
            lsResultData <= randBits(32);
            lsBusy[v] = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        allocEn = 1'b0;
        allocOperandO = '0;
        allocOperandT = '0;
        allocTagO = rsTypesPkg::tagFree;
        allocTagT = rsTypesPkg::tagFree;
        allocTagW = rsTypesPkg::aluTagBase;
        allocOp = aluOpPkg::opNop;
        allocImm = '0;
        allocBranchMask = '0;
        lsResultValid = 1'b0;
        lsResultTag = rsTypesPkg::tagFree;
        lsResultData = '0;
        bFreeEn = 1'b0;
        bFreeId = '0;
        misTaken = 1'b0;
        lfsrState = 16'd65;
        lOcc = '0;
        lNew = '0;
        s1Valid = 1'b0;
        s2Valid = 1'b0;
        brBusy = '0;
        lsBusy = '0;
        allocated = 0;
        completed = 0;
        flushed = 0;
        drained = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (cycle = 0; cycle < 2000; cycle++) begin
            @(negedge clk);
            stepModel();
            @(posedge clk);
            driveCycle(1'b0);
        end
        // no new work while every load returns and the station empties
        for (cycle = 0; cycle < 300 && !drained; cycle++) begin
            @(negedge clk);
            stepModel();
            drained = (lOcc == '0) && !s1Valid && !s2Valid && (lsBusy == '0)
                && (freeMask == '1) && !aluResultValid;
            @(posedge clk);
            driveCycle(1'b1);
        end
        if (!drained) begin
            failRun("drain timed out with instructions still in the cluster");
        end else if (allocated != completed + flushed) begin
            failRun($sformatf("%0d allocated but %0d completed and %0d flushed",
                allocated, completed, flushed));
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end
endmodule

`default_nettype wire

/* aluOpPkg.sv */
`default_nettype none

package aluOpPkg;

    typedef enum logic [3:0] {
        opNop    = 4'd0,
        opAdd    = 4'd1,
        opSub    = 4'd2,
        opAnd    = 4'd3,
        opOr     = 4'd4,
        opXor    = 4'd5,
        opSlt    = 4'd6,
        opAddImm = 4'd7
    } aluOpT;

    // immediate replaces operand T for opAddImm
    function automatic logic usesOperandT(aluOpT op);
        return op != opAddImm;
    endfunction

endpackage

`default_nettype wire

/* aluRs.sv */
`timescale 1ns/1ps
`default_nettype none

module aluRs (
    input wire clk,
    input wire rst,
    dispatchIf.station dispatch,
    input wire aluResultValid,
    input wire rsTypesPkg::tagT aluResultTag,
    input wire rsTypesPkg::dataT aluResultData,
    input wire lsResultValid,
    input wire rsTypesPkg::tagT lsResultTag,
    input wire rsTypesPkg::dataT lsResultData,
    input wire bFreeEn,
    input wire rsTypesPkg::branchIdT bFreeId,
    input wire misTaken,
    issueIf.station issue,
    output logic [rsTypesPkg::rsSize-1:0] freeMask
);
    logic [rsTypesPkg::rsSize-1:0] empty;
    logic [rsTypesPkg::rsSize-1:0] nextEmpty;
    logic [rsTypesPkg::rsSize-1:0] ready;
    logic [rsTypesPkg::rsSize-1:0] sel;
    logic [rsTypesPkg::rsSize-1:0] lineAlloc;
    rsTypesPkg::tagT allocOffset;
    logic [rsTypesPkg::rsIndexWidth-1:0] allocIndex;
    logic [rsTypesPkg::rsIndexWidth-1:0] selIndex;

    rsTypesPkg::dataT lineOperandO [rsTypesPkg::rsSize];
    rsTypesPkg::dataT lineOperandT [rsTypesPkg::rsSize];
    aluOpPkg::aluOpT lineOp [rsTypesPkg::rsSize];
    rsTypesPkg::dataT lineImm [rsTypesPkg::rsSize];
    rsTypesPkg::tagT lineTagW [rsTypesPkg::rsSize];
    rsTypesPkg::branchMaskT lineMask [rsTypesPkg::rsSize];

    // alu tag names its own line
    assign allocOffset = dispatch.tagW - rsTypesPkg::aluTagBase;
    assign allocIndex = allocOffset[rsTypesPkg::rsIndexWidth-1:0];

    for (genvar g = 0; g < rsTypesPkg::rsSize; g++) begin : lineGen
        assign lineAlloc[g] = dispatch.allocEn && (allocIndex == g);

        rsLine rsLine_inst (
            .clk(clk),
            .rst(rst),
            .allocEn(lineAlloc[g]),
            .allocOperandO(dispatch.operandO),
            .allocOperandT(dispatch.operandT),
            .allocTagO(dispatch.tagO),
            .allocTagT(dispatch.tagT),
            .allocTagW(dispatch.tagW),
            .allocOp(dispatch.op),
            .allocImm(dispatch.imm),
            .allocBranchMask(dispatch.branchMask),
            .aluResultValid(aluResultValid),
            .aluResultTag(aluResultTag),
            .aluResultData(aluResultData),
            .lsResultValid(lsResultValid),
            .lsResultTag(lsResultTag),
            .lsResultData(lsResultData),
            .bFreeEn(bFreeEn),
            .bFreeId(bFreeId),
            .misTaken(misTaken),
            .empty(empty[g]),
            .ready(ready[g]),
            .issueOperandO(lineOperandO[g]),
            .issueOperandT(lineOperandT[g]),
            .issueOp(lineOp[g]),
            .issueImm(lineImm[g]),
            .issueTagW(lineTagW[g]),
            .issueBranchMask(lineMask[g]),
            .nextEmpty(nextEmpty[g])
        );
    end

    // lowest ready line wins
    assign sel = ready & (~ready + 1'b1);

    always_comb begin
        selIndex = '0;
        for (int i = rsTypesPkg::rsSize - 1; i >= 0; i--) begin
            if (ready[i]) begin
                selIndex = i[rsTypesPkg::rsIndexWidth-1:0];
            end
        end
    end

    assign freeMask = nextEmpty | sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            empty <= '1;
        end else begin
            empty <= freeMask;
        end
    end

    // register refills or idles every cycle because the alu never stalls
    always_ff @(posedge clk) begin
        if (rst || sel == '0) begin
            issue.issueValid <= 1'b0;
            issue.operandO <= rsTypesPkg::dataFree;
            issue.operandT <= rsTypesPkg::dataFree;
            issue.op <= aluOpPkg::opNop;
            issue.imm <= rsTypesPkg::dataFree;
            issue.tagW <= rsTypesPkg::tagFree;
            issue.branchMask <= '0;
        end else begin
            issue.issueValid <= 1'b1;
            issue.operandO <= lineOperandO[selIndex];
            issue.operandT <= lineOperandT[selIndex];
            issue.op <= lineOp[selIndex];
            issue.imm <= lineImm[selIndex];
            issue.tagW <= lineTagW[selIndex];
            issue.branchMask <= lineMask[selIndex];
        end
    end

    // select vector and muxed line index must name the same line
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(sel) && (sel == '0 || sel[selIndex]))
        else $error("issue select disagrees with the selected line index");
endmodule

`default_nettype wire

/* aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input wire clk,
    input wire rst,
    issueIf.unit issue,
    input wire bFreeEn,
    input wire rsTypesPkg::branchIdT bFreeId,
    input wire misTaken,
    output logic resultValid,
    output rsTypesPkg::tagT resultTag,
    output rsTypesPkg::dataT resultData
);
    rsTypesPkg::dataT srcB;
    rsTypesPkg::dataT result;
    rsTypesPkg::branchMaskT liveMask;
    logic lessThan;
    logic accept;

    assign srcB = aluOpPkg::usesOperandT(issue.op) ? issue.operandT : issue.imm;
    assign lessThan = $signed(issue.operandO) < $signed(srcB);

    // a freed branch can no longer kill this instruction
    assign liveMask = bFreeEn ? (issue.branchMask & ~(rsTypesPkg::branchMaskT'(1) << bFreeId))
        : issue.branchMask;
    assign accept = issue.issueValid && !(misTaken && liveMask[bFreeId]);

    always_comb begin
        case (issue.op)
            aluOpPkg::opAdd, aluOpPkg::opAddImm: result = issue.operandO + srcB;
            aluOpPkg::opSub: result = issue.operandO - srcB;
            aluOpPkg::opAnd: result = issue.operandO & srcB;
            aluOpPkg::opOr: result = issue.operandO | srcB;
            aluOpPkg::opXor: result = issue.operandO ^ srcB;
            aluOpPkg::opSlt: result = rsTypesPkg::dataT'(lessThan);
            default: result = rsTypesPkg::dataFree;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            resultTag <= rsTypesPkg::tagFree;
        end else begin
            resultValid <= accept;
            resultTag <= accept ? issue.tagW : rsTypesPkg::tagFree;
        end
    end

    always_ff @(posedge clk) begin
        resultData <= result;
    end

    // broadcast tag must wake something up
    assert property (@(posedge clk) disable iff (rst)
        resultValid |-> resultTag != rsTypesPkg::tagFree)
        else $error("result broadcast with free tag");
endmodule

`default_nettype wire

/* dispatchIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface dispatchIf;
    logic allocEn;
    rsTypesPkg::dataT operandO;
    rsTypesPkg::dataT operandT;
    rsTypesPkg::tagT tagO;
    rsTypesPkg::tagT tagT;
    rsTypesPkg::tagT tagW;
    aluOpPkg::aluOpT op;
    rsTypesPkg::dataT imm;
    rsTypesPkg::branchMaskT branchMask;

    modport dispatcher (
        output allocEn, operandO, operandT, tagO, tagT, tagW, op, imm, branchMask
    );

    modport station (
        input allocEn, operandO, operandT, tagO, tagT, tagW, op, imm, branchMask
    );

endinterface

`default_nettype wire

/* issueIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface issueIf;
    logic issueValid;
    rsTypesPkg::dataT operandO;
    rsTypesPkg::dataT operandT;
    aluOpPkg::aluOpT op;
    rsTypesPkg::dataT imm;
    rsTypesPkg::tagT tagW;
    rsTypesPkg::branchMaskT branchMask;

    modport station (
        output issueValid, operandO, operandT, op, imm, tagW, branchMask
    );

    modport unit (
        input issueValid, operandO, operandT, op, imm, tagW, branchMask
    );

endinterface

`default_nettype wire

/* operandWakeup.sv */
`timescale 1ns/1ps
`default_nettype none

module operandWakeup (
    input wire lsValid,
    input wire rsTypesPkg::tagT lsTag,
    input wire rsTypesPkg::dataT lsData,
    input wire aluValid,
    input wire rsTypesPkg::tagT aluTag,
    input wire rsTypesPkg::dataT aluData,
    input wire rsTypesPkg::tagT tagNow,
    input wire rsTypesPkg::dataT dataNow,
    output rsTypesPkg::tagT tagNext,
    output rsTypesPkg::dataT dataNext
);
    logic aluHit;
    logic lsHit;

    assign aluHit = aluValid && (tagNow == aluTag);
    assign lsHit = lsValid && (tagNow == lsTag);

    // alu bus wins when both carry the tag
    assign tagNext = (aluHit || lsHit) ? rsTypesPkg::tagFree : tagNow;
    assign dataNext = aluHit ? aluData : (lsHit ? lsData : dataNow);
endmodule

`default_nettype wire

/* rsLine.sv */
`timescale 1ns/1ps
`default_nettype none

module rsLine (
    input wire clk,
    input wire rst,
    input wire allocEn,
    input wire rsTypesPkg::dataT allocOperandO,
    input wire rsTypesPkg::dataT allocOperandT,
    input wire rsTypesPkg::tagT allocTagO,
    input wire rsTypesPkg::tagT allocTagT,
    input wire rsTypesPkg::tagT allocTagW,
    input wire aluOpPkg::aluOpT allocOp,
    input wire rsTypesPkg::dataT allocImm,
    input wire rsTypesPkg::branchMaskT allocBranchMask,
    input wire aluResultValid,
    input wire rsTypesPkg::tagT aluResultTag,
    input wire rsTypesPkg::dataT aluResultData,
    input wire lsResultValid,
    input wire rsTypesPkg::tagT lsResultTag,
    input wire rsTypesPkg::dataT lsResultData,
    input wire bFreeEn,
    input wire rsTypesPkg::branchIdT bFreeId,
    input wire misTaken,
    input wire empty,
    output logic ready,
    output rsTypesPkg::dataT issueOperandO,
    output rsTypesPkg::dataT issueOperandT,
    output aluOpPkg::aluOpT issueOp,
    output rsTypesPkg::dataT issueImm,
    output rsTypesPkg::tagT issueTagW,
    output rsTypesPkg::branchMaskT issueBranchMask,
    output logic nextEmpty
);
    rsTypesPkg::tagT srcTagO;
    rsTypesPkg::tagT srcTagT;
    rsTypesPkg::dataT srcDataO;
    rsTypesPkg::dataT srcDataT;
    aluOpPkg::aluOpT op;
    rsTypesPkg::dataT imm;
    rsTypesPkg::tagT tagW;
    rsTypesPkg::branchMaskT branchMask;

    rsTypesPkg::tagT tagNowO;
    rsTypesPkg::tagT tagNowT;
    rsTypesPkg::dataT dataNowO;
    rsTypesPkg::dataT dataNowT;
    rsTypesPkg::tagT tagNextO;
    rsTypesPkg::tagT tagNextT;
    rsTypesPkg::dataT dataNextO;
    rsTypesPkg::dataT dataNextT;
    rsTypesPkg::branchMaskT maskNow;
    rsTypesPkg::branchMaskT maskNext;
    logic kill;

    // incoming fields see the result buses in the allocation cycle too
    assign tagNowO = allocEn ? allocTagO : srcTagO;
    assign tagNowT = allocEn ? allocTagT : srcTagT;
    assign dataNowO = allocEn ? allocOperandO : srcDataO;
    assign dataNowT = allocEn ? allocOperandT : srcDataT;
    assign maskNow = allocEn ? allocBranchMask : branchMask;
    assign maskNext = bFreeEn ? (maskNow & ~(rsTypesPkg::branchMaskT'(1) << bFreeId)) : maskNow;

    // drop held or arriving instruction under the mispredicted branch
    assign kill = misTaken && maskNext[bFreeId] && (allocEn || !empty);
    assign nextEmpty = (empty && !allocEn) || kill;
    assign ready = !empty && !kill && (tagNextO == rsTypesPkg::tagFree)
        && (tagNextT == rsTypesPkg::tagFree);

    // next-state data bypasses a same-cycle wakeup
    assign issueOperandO = dataNextO;
    assign issueOperandT = dataNextT;
    assign issueOp = op;
    assign issueImm = imm;
    assign issueTagW = tagW;
    assign issueBranchMask = maskNext;

    operandWakeup wakeupO_inst (
        .lsValid(lsResultValid),
        .lsTag(lsResultTag),
        .lsData(lsResultData),
        .aluValid(aluResultValid),
        .aluTag(aluResultTag),
        .aluData(aluResultData),
        .tagNow(tagNowO),
        .dataNow(dataNowO),
        .tagNext(tagNextO),
        .dataNext(dataNextO)
    );

    operandWakeup wakeupT_inst (
        .lsValid(lsResultValid),
        .lsTag(lsResultTag),
        .lsData(lsResultData),
        .aluValid(aluResultValid),
        .aluTag(aluResultTag),
        .aluData(aluResultData),
        .tagNow(tagNowT),
        .dataNow(dataNowT),
        .tagNext(tagNextT),
        .dataNext(dataNextT)
    );

    always_ff @(posedge clk) begin
        if (rst || kill) begin
            srcTagO <= rsTypesPkg::tagFree;
            srcTagT <= rsTypesPkg::tagFree;
            op <= aluOpPkg::opNop;
            branchMask <= '0;
        end else begin
            srcTagO <= tagNextO;
            srcTagT <= tagNextT;
            branchMask <= maskNext;
            if (allocEn) begin
                op <= allocOp;
            end
        end
    end

    always_ff @(posedge clk) begin
        srcDataO <= dataNextO;
        srcDataT <= dataNextT;
        if (allocEn) begin
            imm <= allocImm;
            tagW <= allocTagW;
        end
    end

    // dispatcher must respect freeMask
    assert property (@(posedge clk) disable iff (rst) allocEn |-> empty)
        else $error("allocation into an occupied line");
endmodule

`default_nettype wire

/* rsTypesPkg.sv */
`default_nettype none

package rsTypesPkg;

    // datapath and tag widths
    localparam int dataWidth = 32;
    localparam int tagWidth = 4;
    localparam int branchWidth = 4;
    localparam int branchIdWidth = 2;

    // station geometry
    localparam int rsSize = 4;
    localparam int rsIndexWidth = 2;

    typedef logic [dataWidth-1:0] dataT;
    typedef logic [tagWidth-1:0] tagT;
    typedef logic [branchWidth-1:0] branchMaskT;
    typedef logic [branchIdWidth-1:0] branchIdT;

    // no tag pending so the operand value is present
    localparam tagT tagFree = 4'd15;
    // alu tags 0..3 with the line index in the low bits
    localparam tagT aluTagBase = 4'd0;
    // load/store tags 8..14
    localparam tagT lsTagBase = 4'd8;

    localparam dataT dataFree = '0;

endpackage

`default_nettype wire

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module aluClusterTb
./obj_dir/ValuClusterTb > sim.log 2>&1 || true
cat sim.log
if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
grep -q "PASS: all tests" sim.log

/* vlog.f */
rsTypesPkg.sv
aluOpPkg.sv
dispatchIf.sv
issueIf.sv
operandWakeup.sv
rsLine.sv
aluRs.sv
aluUnit.sv
aluCluster.sv
aluClusterTb.sv
